// File: common/regex_pkg.sv
// memory is fixed at 512 bytes read as 64-bit words; byte pointers need 10 bits to hold 512
package regex_pkg;

    ////////////////////////////////////////////////////////////
    // widths and memory map
    ////////////////////////////////////////////////////////////
    localparam int REG_WIDTH       = 32;
    localparam int MEM_READ_WIDTH  = 64;
    localparam int MEM_WRITE_WIDTH = 32;
    localparam int MEM_BYTES       = 512;
    localparam int CHAR_WIDTH      = 8;
    localparam int MEM_RWORDS      = MEM_BYTES / (MEM_READ_WIDTH / CHAR_WIDTH);
    localparam int MEM_WWORDS      = MEM_BYTES / (MEM_WRITE_WIDTH / CHAR_WIDTH);

    // bitmap lives in bytes 0..31, text may start right after it
    localparam int CC_WORDS        = 4;
    localparam int TEXT_BASE       = 32;

    typedef logic [REG_WIDTH-1:0]             reg_word_t;
    typedef logic [MEM_READ_WIDTH-1:0]        mem_word_t;
    typedef logic [$clog2(MEM_RWORDS)-1:0]    mem_raddr_t;
    typedef logic [$clog2(MEM_WWORDS)-1:0]    mem_waddr_t;
    typedef logic [$clog2(MEM_BYTES):0]       char_addr_t;
    typedef logic [2:0]                       cmd_code_t;

    ////////////////////////////////////////////////////////////
    // host commands and status
    ////////////////////////////////////////////////////////////
    localparam cmd_code_t CMD_NOP          = 3'd0;
    localparam cmd_code_t CMD_WRITE        = 3'd1;
    localparam cmd_code_t CMD_READ         = 3'd2;
    localparam cmd_code_t CMD_START        = 3'd3;
    localparam cmd_code_t CMD_RESTART      = 3'd4;
    localparam cmd_code_t CMD_READ_ELAPSED = 3'd5;

    typedef enum logic [2:0] {
        STATUS_IDLE     = 3'd0,
        STATUS_RUNNING  = 3'd1,
        STATUS_ACCEPTED = 3'd2,
        STATUS_REJECTED = 3'd3,
        STATUS_ERROR    = 3'd4
    } status_t;

endpackage

// File: hw/char_mem.sv
// no reset on the array; a read in the same cycle as a write to that word returns the old data
`timescale 1ns/100ps

module char_mem
    import regex_pkg::*;
(
    input  logic       clk,
    input  logic       wr_en,
    input  mem_waddr_t wr_addr,
    input  reg_word_t  wr_data,
    input  logic       rd_en,
    input  mem_raddr_t rd_addr,
    output mem_word_t  rd_data
);

    mem_word_t mem [MEM_RWORDS];

    // write port, 32 bits wide, bit 0 of the address picks the half
    always_ff @(posedge clk)
    begin
        if (wr_en)
        begin
            if (wr_addr[0])
            begin
                mem[wr_addr[$bits(mem_waddr_t)-1:1]][MEM_WRITE_WIDTH +: MEM_WRITE_WIDTH]
                    <= wr_data;
            end
            else
            begin
                mem[wr_addr[$bits(mem_waddr_t)-1:1]][0 +: MEM_WRITE_WIDTH] <= wr_data;
            end
        end
    end

    // registered read, holds the last word while idle
    always_ff @(posedge clk)
    begin
        if (rd_en)
        begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

// File: hw/mem_arbiter.sv
// engine always wins; the controller keeps at most one host read in flight
`timescale 1ns/100ps

module mem_arbiter
    import regex_pkg::*;
(
    input  logic       clk,
    input  logic       rst_master,
    input  logic       host_req,
    input  mem_raddr_t host_raddr,
    input  logic       eng_req,
    input  mem_raddr_t eng_raddr,
    output logic       rd_en,
    output mem_raddr_t rd_addr,
    output logic       host_rvalid,
    output logic       eng_rvalid
);

    logic       host_pend;
    mem_raddr_t host_pend_addr;
    logic       host_any;
    logic       rd_valid_q;
    logic       owner_eng_q;

    assign host_any = host_req || host_pend;

    // grant
    assign rd_en   = eng_req || host_any;
    assign rd_addr = eng_req   ? eng_raddr :
                     host_pend ? host_pend_addr : host_raddr;

    always_ff @(posedge clk)
    begin
        if (rst_master)
        begin
            host_pend   <= 1'b0;
            rd_valid_q  <= 1'b0;
            owner_eng_q <= 1'b0;
        end
        else
        begin
            // host held back while the engine owns the port
            if (eng_req && host_req)
                host_pend <= 1'b1;
            else if (!eng_req)
                host_pend <= 1'b0;
            rd_valid_q  <= rd_en;
            owner_eng_q <= eng_req;
        end
    end

    always_ff @(posedge clk)
    begin
        if (host_req)
            host_pend_addr <= host_raddr;
    end

    // owner tag steers the returning word
    assign host_rvalid = rd_valid_q && !owner_eng_q;
    assign eng_rvalid  = rd_valid_q && owner_eng_q;

    // a second host read while one waits would be lost
    assert property (@(posedge clk) disable iff (rst_master) host_req |-> !host_pend);

endmodule

// File: hw/cmd_ctrl.sv
// commands are single-cycle strobes; a memory read returning in the same cycle as READ_ELAPSED wins
`timescale 1ns/100ps

module cmd_ctrl
    import regex_pkg::*;
(
    input  logic       clk,
    input  logic       rst_master,
    input  logic       cmd_valid,
    input  cmd_code_t  cmd,
    input  reg_word_t  addr,
    input  reg_word_t  wdata,
    input  char_addr_t start_ptr,
    input  char_addr_t end_ptr,
    output status_t    status,
    output reg_word_t  rdata,
    output logic       rdata_valid,
    output logic       mem_wr_en,
    output mem_waddr_t mem_wr_addr,
    output reg_word_t  mem_wr_data,
    output logic       host_req,
    output mem_raddr_t host_raddr,
    input  logic       host_rvalid,
    input  mem_word_t  mem_rdata,
    output logic       eng_start,
    output char_addr_t eng_start_ptr,
    output char_addr_t eng_end_ptr,
    input  logic       eng_done,
    input  logic       eng_accept,
    input  logic       eng_error
);

    logic      is_write;
    logic      is_read;
    logic      is_start;
    logic      is_restart;
    logic      is_elapsed;
    logic      is_final;
    logic      read_pend;
    logic      read_half;
    reg_word_t elapsed;

    always_comb
    begin
        is_write   = 1'b0;
        is_read    = 1'b0;
        is_start   = 1'b0;
        is_restart = 1'b0;
        is_elapsed = 1'b0;
        case (cmd)
            CMD_NOP:          ;
            CMD_WRITE:        is_write   = cmd_valid;
            CMD_READ:         is_read    = cmd_valid;
            CMD_START:        is_start   = cmd_valid;
            CMD_RESTART:      is_restart = cmd_valid;
            CMD_READ_ELAPSED: is_elapsed = cmd_valid;
            default:          ;
        endcase
    end

    assign is_final = (status == STATUS_ACCEPTED) || (status == STATUS_REJECTED) ||
                      (status == STATUS_ERROR);

    // memory side, writes blocked during a run
    assign mem_wr_en     = is_write && (status != STATUS_RUNNING);
    assign mem_wr_addr   = addr[$bits(mem_waddr_t)-1:0];
    assign mem_wr_data   = wdata;
    assign host_req      = is_read && !read_pend;
    assign host_raddr    = addr[$bits(mem_raddr_t):1];

    assign eng_start     = is_start && (status == STATUS_IDLE);
    assign eng_start_ptr = start_ptr;
    assign eng_end_ptr   = end_ptr;

    ////////////////////////////////////////////////////////////
    // status FSM and elapsed counter
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (rst_master)
        begin
            status  <= STATUS_IDLE;
            elapsed <= '0;
        end
        else
        begin
            case (status)
                STATUS_IDLE:
                begin
                    if (eng_start)
                    begin
                        status  <= STATUS_RUNNING;
                        elapsed <= '0;
                    end
                end
                STATUS_RUNNING:
                begin
                    if (!(&elapsed))
                        elapsed <= elapsed + 1'b1;
                    if (eng_done)
                        status <= eng_error  ? STATUS_ERROR :
                                  eng_accept ? STATUS_ACCEPTED : STATUS_REJECTED;
                end
                default:
                begin
                    if (is_restart && is_final)
                        status <= STATUS_IDLE;
                end
            endcase
        end
    end

    // read return path
    always_ff @(posedge clk)
    begin
        if (rst_master)
        begin
            read_pend   <= 1'b0;
            rdata_valid <= 1'b0;
        end
        else
        begin
            if (host_req)
                read_pend <= 1'b1;
            else if (host_rvalid)
                read_pend <= 1'b0;
            rdata_valid <= host_rvalid || is_elapsed;
        end
    end

    always_ff @(posedge clk)
    begin
        if (host_req)
            read_half <= addr[0];
        if (host_rvalid)
            rdata <= mem_rdata[read_half*REG_WIDTH +: REG_WIDTH];
        else if (is_elapsed)
            rdata <= elapsed;
    end

    assert property (@(posedge clk) disable iff (rst_master) eng_done |-> status == STATUS_RUNNING);

endmodule

// File: cc_engine/cc_engine.sv
// expects start only while idle; one memory read in flight, bitmap reloaded on every run
`timescale 1ns/100ps

module cc_engine
    import regex_pkg::*;
(
    input  logic       clk,
    input  logic       rst_master,
    input  logic       start,
    input  char_addr_t start_ptr,
    input  char_addr_t end_ptr,
    output logic       mem_req,
    output mem_raddr_t mem_raddr,
    input  logic       mem_rvalid,
    input  mem_word_t  mem_rdata,
    output logic       done,
    output logic       accept,
    output logic       error
);

    typedef enum logic [2:0] {
        ENG_IDLE,
        ENG_CHECK,
        ENG_LOAD_CC,
        ENG_SCAN,
        ENG_FINISH
    } eng_state_t;

    eng_state_t                    state;
    char_addr_t                    cur_ptr;
    char_addr_t                    end_q;
    logic [$clog2(CC_WORDS)-1:0]   cc_idx;
    logic [CC_WORDS*MEM_READ_WIDTH-1:0] bitmap;
    mem_word_t                     text_word;
    logic                          word_ok;
    logic                          req_pend;
    logic [CHAR_WIDTH-1:0]         cur_byte;
    logic                          scan_end;

    assign scan_end = (cur_ptr == end_q);
    assign cur_byte = text_word[cur_ptr[2:0]*CHAR_WIDTH +: CHAR_WIDTH];

    // fetch requests, bitmap words first, then text words on demand
    assign mem_req   = !req_pend &&
                       ((state == ENG_LOAD_CC) ||
                        (state == ENG_SCAN && !word_ok && !scan_end));
    assign mem_raddr = (state == ENG_LOAD_CC) ? mem_raddr_t'(cc_idx)
                                              : cur_ptr[$bits(mem_raddr_t)+2:3];
    assign done      = (state == ENG_FINISH);

    always_ff @(posedge clk)
    begin
        if (rst_master)
        begin
            state    <= ENG_IDLE;
            req_pend <= 1'b0;
            word_ok  <= 1'b0;
            accept   <= 1'b0;
            error    <= 1'b0;
        end
        else
        begin
            if (mem_req)
                req_pend <= 1'b1;
            else if (mem_rvalid)
                req_pend <= 1'b0;

            case (state)
                ENG_IDLE:
                begin
                    if (start)
                        state <= ENG_CHECK;
                end
                ENG_CHECK:
                begin
                    word_ok <= 1'b0;
                    if (end_q < cur_ptr || cur_ptr < char_addr_t'(TEXT_BASE) ||
                        end_q > char_addr_t'(MEM_BYTES))
                    begin
                        error  <= 1'b1;
                        accept <= 1'b0;
                        state  <= ENG_FINISH;
                    end
                    else
                    begin
                        error <= 1'b0;
                        state <= ENG_LOAD_CC;
                    end
                end
                ENG_LOAD_CC:
                begin
                    if (mem_rvalid && cc_idx == CC_WORDS - 1)
                        state <= ENG_SCAN;
                end
                ENG_SCAN:
                begin
                    if (scan_end)
                    begin
                        accept <= 1'b1;
                        state  <= ENG_FINISH;
                    end
                    else if (!word_ok)
                    begin
                        if (mem_rvalid)
                            word_ok <= 1'b1;
                    end
                    else if (!bitmap[cur_byte])
                    begin
                        accept <= 1'b0;
                        state  <= ENG_FINISH;
                    end
                    else if (&cur_ptr[2:0])
                    begin
                        // next byte sits in the following word
                        word_ok <= 1'b0;
                    end
                end
                default:
                    state <= ENG_IDLE;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////
    // datapath, no reset
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (state == ENG_IDLE && start)
        begin
            cur_ptr <= start_ptr;
            end_q   <= end_ptr;
        end
        else if (state == ENG_SCAN && word_ok && !scan_end && bitmap[cur_byte])
        begin
            cur_ptr <= cur_ptr + 1'b1;
        end

        if (state == ENG_CHECK)
            cc_idx <= '0;
        else if (state == ENG_LOAD_CC && mem_rvalid)
        begin
            bitmap[cc_idx*MEM_READ_WIDTH +: MEM_READ_WIDTH] <= mem_rdata;
            cc_idx <= cc_idx + 1'b1;
        end

        if (state == ENG_SCAN && mem_rvalid)
            text_word <= mem_rdata;
    end

    // engine has priority, so each request returns on the very next cycle
    assert property (@(posedge clk) disable iff (rst_master)
        mem_req |=> mem_rvalid && !mem_req);

endmodule

// File: hw/regex_top.sv
// host inputs are sampled only while cmd_valid is high; status is valid every cycle
`timescale 1ns/100ps

module regex_top
    import regex_pkg::*;
(
    input  logic       clk,
    input  logic       rst_master,
    input  logic       cmd_valid,
    input  cmd_code_t  cmd,
    input  reg_word_t  addr,
    input  reg_word_t  wdata,
    input  char_addr_t start_ptr,
    input  char_addr_t end_ptr,
    output status_t    status,
    output reg_word_t  rdata,
    output logic       rdata_valid
);

    logic       mem_wr_en;
    mem_waddr_t mem_wr_addr;
    reg_word_t  mem_wr_data;
    logic       host_req;
    mem_raddr_t host_raddr;
    logic       host_rvalid;
    logic       eng_req;
    mem_raddr_t eng_raddr;
    logic       eng_rvalid;
    logic       rd_en;
    mem_raddr_t rd_addr;
    mem_word_t  rd_data;
    logic       eng_start;
    char_addr_t eng_start_ptr;
    char_addr_t eng_end_ptr;
    logic       eng_done;
    logic       eng_accept;
    logic       eng_error;

    cmd_ctrl u_cmd_ctrl (
        .clk           (clk),
        .rst_master    (rst_master),
        .cmd_valid     (cmd_valid),
        .cmd           (cmd),
        .addr          (addr),
        .wdata         (wdata),
        .start_ptr     (start_ptr),
        .end_ptr       (end_ptr),
        .status        (status),
        .rdata         (rdata),
        .rdata_valid   (rdata_valid),
        .mem_wr_en     (mem_wr_en),
        .mem_wr_addr   (mem_wr_addr),
        .mem_wr_data   (mem_wr_data),
        .host_req      (host_req),
        .host_raddr    (host_raddr),
        .host_rvalid   (host_rvalid),
        .mem_rdata     (rd_data),
        .eng_start     (eng_start),
        .eng_start_ptr (eng_start_ptr),
        .eng_end_ptr   (eng_end_ptr),
        .eng_done      (eng_done),
        .eng_accept    (eng_accept),
        .eng_error     (eng_error)
    );

    mem_arbiter u_mem_arbiter (
        .clk         (clk),
        .rst_master  (rst_master),
        .host_req    (host_req),
        .host_raddr  (host_raddr),
        .eng_req     (eng_req),
        .eng_raddr   (eng_raddr),
        .rd_en       (rd_en),
        .rd_addr     (rd_addr),
        .host_rvalid (host_rvalid),
        .eng_rvalid  (eng_rvalid)
    );

    char_mem u_char_mem (
        .clk     (clk),
        .wr_en   (mem_wr_en),
        .wr_addr (mem_wr_addr),
        .wr_data (mem_wr_data),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    cc_engine u_cc_engine (
        .clk        (clk),
        .rst_master (rst_master),
        .start      (eng_start),
        .start_ptr  (eng_start_ptr),
        .end_ptr    (eng_end_ptr),
        .mem_req    (eng_req),
        .mem_raddr  (eng_raddr),
        .mem_rvalid (eng_rvalid),
        .mem_rdata  (rd_data),
        .done       (eng_done),
        .accept     (eng_accept),
        .error      (eng_error)
    );

endmodule

// File: test/tb_clock.sv
// free-running clock, 100 ns period, starts low at time zero
`timescale 1ns/100ps

module tb_clock
(
    output logic clk
);

    localparam int HALF_PERIOD = 50;

    initial
    begin
        clk = 1'b0;
        forever
            #HALF_PERIOD clk = ~clk;
    end

endmodule

// File: test/regex_tb.sv
// single host thread on falling edges; memory is fully written before the first read
`timescale 1ns/100ps

module regex_tb
    import regex_pkg::*;
();

    localparam int NUM_RUNS        = 40;
    localparam int RUN_TIMEOUT     = 1500;
    localparam int READ_TIMEOUT    = 20;
    localparam int FILL_CYCLES     = 2000;
    localparam int READBACK_CHECKS = 64;
    localparam int WATCHDOG_CYCLES = NUM_RUNS * RUN_TIMEOUT + FILL_CYCLES;

    logic       clk;
    logic       rst_master;
    logic       cmd_valid;
    cmd_code_t  cmd;
    reg_word_t  addr;
    reg_word_t  wdata;
    char_addr_t start_ptr;
    char_addr_t end_ptr;
    status_t    status;
    reg_word_t  rdata;
    logic       rdata_valid;

    logic [31:0] rng_state = 32'h13e6_5d7d;
    logic [7:0]  model [MEM_BYTES];
    int          mismatches = 0;
    int          other_errors = 0;
    int          running_total = 0;
    int          valid_pulses = 0;
    int          expected_valids = 0;
    int          accepted_runs = 0;
    int          rejected_runs = 0;

    tb_clock clk_gen_i (.clk(clk));

    regex_top dut_i (
        .clk         (clk),
        .rst_master  (rst_master),
        .cmd_valid   (cmd_valid),
        .cmd         (cmd),
        .addr        (addr),
        .wdata       (wdata),
        .start_ptr   (start_ptr),
        .end_ptr     (end_ptr),
        .status      (status),
        .rdata       (rdata),
        .rdata_valid (rdata_valid)
    );

    ////////////////////////////////////////////////////////////
    // random numbers and reference model
    ////////////////////////////////////////////////////////////
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = next_rand();
        return int'(r % 32'(n));
    endfunction

    // byte 4w sits in the low bits
    function automatic logic [31:0] model_word(input int w);
        return {model[4*w+3], model[4*w+2], model[4*w+1], model[4*w]};
    endfunction

    // bit c%8 of bitmap byte c/8
    function automatic logic in_class(input logic [7:0] c);
        return model[c[7:3]][c[2:0]];
    endfunction

    function automatic status_t expected_verdict(input int sp, input int ep);
        if (ep < sp || sp < TEXT_BASE || ep > MEM_BYTES)
            return STATUS_ERROR;
        for (int i = sp; i < ep; i++)
        begin
            if (!in_class(model[i]))
                return STATUS_REJECTED;
        end
        return STATUS_ACCEPTED;
    endfunction

    task automatic report_mismatch(input string msg);
        mismatches++;
        $display("mismatch at %0t: %s", $time, msg);
    endtask

    task automatic report_failure(input string msg);
        other_errors++;
        $display("error at %0t: %s", $time, msg);
    endtask

    ////////////////////////////////////////////////////////////
    // host side
    ////////////////////////////////////////////////////////////
    task automatic pulse_cmd(input cmd_code_t c, input int a, input logic [31:0] d,
                             input int sp, input int ep);
        @(negedge clk);
        cmd_valid = 1'b1;
        cmd       = c;
        addr      = reg_word_t'(a);
        wdata     = d;
        start_ptr = char_addr_t'(sp);
        end_ptr   = char_addr_t'(ep);
        @(negedge clk);
        cmd_valid = 1'b0;
        cmd       = CMD_NOP;
    endtask

    task automatic write_word(input int w, input logic [31:0] d);
        pulse_cmd(CMD_WRITE, w, d, 0, 0);
        model[4*w]   = d[7:0];
        model[4*w+1] = d[15:8];
        model[4*w+2] = d[23:16];
        model[4*w+3] = d[31:24];
    endtask

    // status is stable at the falling edge, so RUNNING here holds at the sampling edge
    task automatic write_while_running(input int w, input logic [31:0] d);
        @(negedge clk);
        if (status == STATUS_RUNNING)
        begin
            cmd_valid = 1'b1;
            cmd       = CMD_WRITE;
            addr      = reg_word_t'(w);
            wdata     = d;
            @(negedge clk);
            cmd_valid = 1'b0;
            cmd       = CMD_NOP;
        end
    endtask

    task automatic read_check(input int a);
        logic [31:0] expected;
        int          wait_cycles;
        expected = model_word(a);
        pulse_cmd(CMD_READ, a, 32'h0, 0, 0);
        expected_valids++;
        wait_cycles = 0;
        while (rdata_valid !== 1'b1 && wait_cycles < READ_TIMEOUT)
        begin
            @(negedge clk);
            wait_cycles++;
        end
        if (rdata_valid !== 1'b1)
            report_failure($sformatf("no rdata_valid for READ of word %0d", a));
        else if (rdata !== expected)
            report_mismatch($sformatf("READ word %0d gave %h, expected %h", a, rdata, expected));
    endtask

    ////////////////////////////////////////////////////////////
    // run setup
    ////////////////////////////////////////////////////////////
    task automatic load_class_bitmap();
        logic [31:0] d;
        for (int w = 0; w < TEXT_BASE / 4; w++)
        begin
            d = next_rand() | next_rand();
            // char 0 is always in the class and char 255 never
            if (w == 0)
                d[0] = 1'b1;
            if (w == TEXT_BASE / 4 - 1)
                d[31] = 1'b0;
            write_word(w, d);
        end
    endtask

    task automatic load_text(input int sp, input int ep, input bit all_members);
        logic [31:0] r;
        logic [7:0]  c;
        int          bad_pos;
        for (int i = sp; i < ep; i++)
        begin
            r = next_rand();
            c = r[7:0];
            if (all_members)
            begin
                while (!in_class(c))
                    c = c + 8'd1;
            end
            model[i] = c;
        end
        // one byte outside the class forces a reject
        if (!all_members && ep > sp)
        begin
            bad_pos = sp + rand_below(ep - sp);
            c = model[bad_pos];
            while (in_class(c))
                c = c + 8'd1;
            model[bad_pos] = c;
        end
        if (ep > sp)
        begin
            for (int w = sp / 4; w <= (ep - 1) / 4; w++)
                write_word(w, model_word(w));
        end
    endtask

    task automatic pick_pointers(input int run, output int sp, output int ep);
        int len;
        if (run == 0)
        begin
            sp = MEM_BYTES;
            ep = MEM_BYTES;
        end
        else if (run == 1)
        begin
            sp = TEXT_BASE + rand_below(MEM_BYTES - TEXT_BASE);
            ep = sp;
        end
        else if (run == 2)
        begin
            len = 1 + rand_below(40);
            sp  = MEM_BYTES - len;
            ep  = MEM_BYTES;
        end
        else
        begin
            sp  = TEXT_BASE + rand_below(MEM_BYTES - TEXT_BASE);
            len = rand_below(49);
            if (len > MEM_BYTES - sp)
                len = MEM_BYTES - sp;
            ep  = sp + len;
        end
    endtask

    task automatic run_check(input int sp, input int ep, input bit with_traffic);
        status_t expected;
        status_t verdict;
        int      wait_cycles;
        int      running_before;
        int      probe;
        expected = expected_verdict(sp, ep);
        running_before = running_total;
        pulse_cmd(CMD_START, 0, 32'h0, sp, ep);
        if (status !== STATUS_RUNNING)
            report_mismatch($sformatf("status %s after START", status.name()));
        if (with_traffic)
        begin
            probe = rand_below(MEM_BYTES / 4);
            write_while_running(probe, ~model_word(probe));
            read_check(probe);
            read_check(rand_below(MEM_BYTES / 4));
        end
        wait_cycles = 0;
        while (status == STATUS_RUNNING && wait_cycles < RUN_TIMEOUT)
        begin
            @(negedge clk);
            wait_cycles++;
        end
        verdict = status;
        if (verdict == STATUS_RUNNING)
        begin
            report_failure($sformatf("run %0d..%0d never finished", sp, ep));
            return;
        end
        if (verdict !== expected)
            report_mismatch($sformatf("run %0d..%0d ended %s, expected %s",
                                      sp, ep, verdict.name(), expected.name()));
        if (verdict == STATUS_ACCEPTED)
            accepted_runs++;
        else if (verdict == STATUS_REJECTED)
            rejected_runs++;

        pulse_cmd(CMD_READ_ELAPSED, 0, 32'h0, 0, 0);
        expected_valids++;
        if (rdata_valid !== 1'b1)
            report_failure("no rdata_valid one cycle after READ_ELAPSED");
        else if (rdata !== reg_word_t'(running_total - running_before))
            report_mismatch($sformatf("elapsed %0d, counted %0d RUNNING cycles",
                                      rdata, running_total - running_before));

        // START is ignored in a final state and RESTART in IDLE
        pulse_cmd(CMD_START, 0, 32'h0, TEXT_BASE, TEXT_BASE);
        if (status !== verdict)
            report_mismatch($sformatf("START in %s moved status to %s",
                                      verdict.name(), status.name()));
        pulse_cmd(CMD_RESTART, 0, 32'h0, 0, 0);
        if (status !== STATUS_IDLE)
            report_mismatch($sformatf("status %s after RESTART", status.name()));
        pulse_cmd(CMD_RESTART, 0, 32'h0, 0, 0);
        if (status !== STATUS_IDLE)
            report_mismatch($sformatf("RESTART in IDLE gave %s", status.name()));
    endtask

    ////////////////////////////////////////////////////////////
    // monitors
    ////////////////////////////////////////////////////////////
    always @(negedge clk)
    begin
        if (status == STATUS_RUNNING)
            running_total++;
        if (rdata_valid === 1'b1)
            valid_pulses++;
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        report_failure($sformatf("watchdog expired after %0d cycles", WATCHDOG_CYCLES));
        $display("mismatches %0d, other errors %0d", mismatches, other_errors);
        $display("Test failed");
        $finish;
    end

    initial
    begin
        int sp;
        int ep;
        rst_master = 1'b1;
        cmd_valid  = 1'b0;
        cmd        = CMD_NOP;
        addr       = '0;
        wdata      = '0;
        start_ptr  = '0;
        end_ptr    = '0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_master = 1'b0;
        if (status !== STATUS_IDLE || rdata_valid !== 1'b0)
            report_mismatch($sformatf("after reset status %s rdata_valid %b",
                                      status.name(), rdata_valid));

        // fill the memory and read back random words
        for (int w = 0; w < MEM_BYTES / 4; w++)
            write_word(w, next_rand());
        for (int k = 0; k < READBACK_CHECKS; k++)
            read_check(rand_below(MEM_BYTES / 4));

        for (int run = 0; run < NUM_RUNS; run++)
        begin
            case (run % 8)
                5:
                begin
                    sp = TEXT_BASE + 1 + rand_below(MEM_BYTES - TEXT_BASE - 1);
                    ep = sp - 1 - rand_below(sp);
                end
                6:
                begin
                    sp = rand_below(TEXT_BASE);
                    ep = sp + rand_below(64);
                end
                7:
                begin
                    sp = TEXT_BASE + rand_below(MEM_BYTES - TEXT_BASE);
                    ep = MEM_BYTES + 1 + rand_below(511);
                end
                default:
                begin
                    pick_pointers(run, sp, ep);
                    load_class_bitmap();
                    load_text(sp, ep, run % 2 == 0);
                end
            endcase
            run_check(sp, ep, run % 8 < 5);
        end

        repeat (4) @(negedge clk);
        if (valid_pulses != expected_valids)
            report_mismatch($sformatf("%0d rdata_valid pulses for %0d reads",
                                      valid_pulses, expected_valids));
        if (accepted_runs == 0 || rejected_runs == 0)
            report_failure("runs did not end in both ACCEPTED and REJECTED");
        $display("runs %0d, mismatches %0d, other errors %0d",
                 NUM_RUNS, mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// File: files.f
common/regex_pkg.sv
hw/char_mem.sv
hw/mem_arbiter.sv
hw/cmd_ctrl.sv
cc_engine/cc_engine.sv
hw/regex_top.sv
test/tb_clock.sv
test/regex_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build with Verilator, run, and scan the log for the fail message
set -u
cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module regex_tb -f files.f -o regex_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/regex_sim > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "Test failed" "$LOG"; then
    exit 1
fi
exit 0
